// File: source/cart_pkg.sv
package cart_pkg;

  localparam int SNES_ADDR_W = 24;
  localparam int ROM_ADDR_W  = 23;
  localparam int RAM_ADDR_W  = 19;

  // LoROM map, 4 MB ROM and 32 KB save RAM
  localparam logic [SNES_ADDR_W-1:0] ROM_MASK     = 24'h3fffff;
  localparam logic [SNES_ADDR_W-1:0] SAVERAM_MASK = 24'h007fff;

  // slot lengths in CLK2 cycles
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;
  localparam logic [3:0] RAM_CYCLE_LEN = 4'd5;

  // about 1 ms of CPU clock held low
  localparam logic [17:0] SNES_DEAD_TIMEOUT = 18'd85714;

  localparam logic [4:0] MCU_RAM_REGION = 5'b11100;

  typedef struct packed {
    logic                   read;
    logic                   write;
    logic                   cpu_clk;
    logic                   romsel;
    logic [SNES_ADDR_W-1:0] addr;
  } snes_bus_t;

  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
  } snes_strobe_t;

  typedef struct packed {
    logic [4:0]            region;
    logic [RAM_ADDR_W-1:0] offset;
  } mcu_ram_addr_t;

  // one MCU address, seen as a ROM byte address or as tag plus RAM offset
  typedef union packed {
    logic [SNES_ADDR_W-1:0] flat;
    mcu_ram_addr_t          ram;
  } mcu_addr_u;

  typedef struct packed {
    mcu_addr_u  addr;
    logic       rrq;
    logic       wrq;
    logic [7:0] wdata;
  } mcu_req_t;

  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [SNES_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } mem_req_t;

  // one-hot slot states shared by both sequencers
  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00001,
    ST_RD_ADDR = 5'b00010,
    ST_RD_END  = 5'b00100,
    ST_WR_ADDR = 5'b01000,
    ST_WR_END  = 5'b10000
  } seq_state_e;

endpackage

// File: source/snes_bus_sampler.sv
module snes_bus_sampler (
  input  logic                             CLK2,
  input  logic                             reset,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                             snes_read_in,
  input  logic                             snes_write_in,
  input  logic                             snes_romsel_in,
  input  logic                             snes_cpu_clk_in,
  input  logic [7:0]                       snes_data_raw,
  output cart_pkg::snes_bus_t              bus,
  output cart_pkg::snes_strobe_t           strobe,
  output logic [7:0]                       snes_data_in
);
  import cart_pkg::*;

  // newest sample in bit 0
  logic [6:0] read_hist;
  logic [6:0] write_hist;
  logic [6:0] cpu_clk_hist;
  // romsel only needs its level
  logic [2:0] romsel_hist;

  logic [SNES_ADDR_W-1:0] addr_q;
  logic [3:0][7:0]        data_hist;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_hist    <= '1;
      write_hist   <= '1;
      cpu_clk_hist <= '0;
      romsel_hist  <= '1;
    end else begin
      read_hist    <= {read_hist[5:0], snes_read_in};
      write_hist   <= {write_hist[5:0], snes_write_in};
      cpu_clk_hist <= {cpu_clk_hist[5:0], snes_cpu_clk_in};
      romsel_hist  <= {romsel_hist[1:0], snes_romsel_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_q    <= snes_addr_in;
    data_hist <= {data_hist[2:0], snes_data_raw};
  end

  // levels from stages two and three
  assign bus = '{
    read:    read_hist[2] & read_hist[1],
    write:   write_hist[2] & write_hist[1],
    cpu_clk: cpu_clk_hist[2] & cpu_clk_hist[1],
    romsel:  romsel_hist[2] & romsel_hist[1],
    addr:    addr_q
  };

  // edges need five stable samples before the change
  assign strobe = '{
    rd_start:    read_hist[6:1] == 6'b111110,
    rd_end:      read_hist[6:1] == 6'b000001,
    wr_end:      write_hist[6:1] == 6'b000001,
    cycle_start: cpu_clk_hist[6:1] == 6'b000001,
    cycle_end:   cpu_clk_hist[6:1] == 6'b111110
  };

  // glitch filter on the write data
  assign snes_data_in = data_hist[3] & data_hist[2];

endmodule

// File: source/snes_liveness.sv
module snes_liveness (
  input  logic                CLK2,
  input  logic                reset,
  input  cart_pkg::snes_bus_t bus,
  output logic                snes_dead,
  output logic                snes_reset_strobe
);
  import cart_pkg::*;

  logic [17:0] dead_cnt;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt          <= '0;
      snes_dead         <= 1'b1;
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (bus.cpu_clk) begin
        dead_cnt          <= '0;
        snes_dead         <= 1'b0;
        // wake-up pulse only after a dead period
        snes_reset_strobe <= snes_dead;
      end else begin
        // saturate just past the timeout
        if (dead_cnt <= SNES_DEAD_TIMEOUT)
          dead_cnt <= dead_cnt + 18'd1;
        if (dead_cnt > SNES_DEAD_TIMEOUT)
          snes_dead <= 1'b1;
      end
    end
  end

endmodule

// File: source/cart_addr_map.sv
module cart_addr_map (
  input  cart_pkg::snes_bus_t              bus,
  output logic                             is_rom,
  output logic                             is_saveram,
  output logic [cart_pkg::SNES_ADDR_W-1:0] rom_map_addr,
  output logic [cart_pkg::RAM_ADDR_W-1:0]  ram_map_addr
);
  import cart_pkg::*;

  logic [7:0] bank;

  assign bank = bus.addr[23:16];

  // save RAM in banks 70-7d, lower half of each bank
  assign is_saveram = (bank >= 8'h70) && (bank <= 8'h7d) && !bus.addr[15];

  // everything else behind romsel
  assign is_rom = !bus.romsel && !is_saveram;

  // LoROM folds out address bit 15
  assign rom_map_addr = {2'b00, bank[6:0], bus.addr[14:0]} & ROM_MASK;

  assign ram_map_addr = {bank[3:0], bus.addr[14:0]} & SAVERAM_MASK[RAM_ADDR_W-1:0];

endmodule

// File: source/mcu_req_router.sv
module mcu_req_router (
  input  logic               CLK2,
  input  logic               reset,
  input  cart_pkg::mcu_req_t mcu_req,
  input  logic               rom_done,
  input  logic               ram_done,
  input  logic [7:0]         rom_rd_byte,
  input  logic [7:0]         ram_rd_byte,
  output cart_pkg::mem_req_t rom_req,
  output cart_pkg::mem_req_t ram_req,
  output logic               mcu_rdy,
  output logic [7:0]         mcu_rdata
);
  import cart_pkg::*;

  logic new_req;
  logic to_ram;
  logic rom_rdy;
  logic ram_rdy;

  assign new_req = mcu_req.rrq | mcu_req.wrq;
  assign to_ram  = mcu_req.addr.ram.region == MCU_RAM_REGION;

  // --------------------
  // pending records
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rom_req.rd <= 1'b0;
      rom_req.wr <= 1'b0;
      ram_req.rd <= 1'b0;
      ram_req.wr <= 1'b0;
      rom_rdy    <= 1'b1;
      ram_rdy    <= 1'b1;
    end else begin
      if (new_req && !to_ram) begin
        rom_req.rd   <= mcu_req.rrq;
        rom_req.wr   <= mcu_req.wrq;
        rom_req.addr <= mcu_req.addr.flat;
        rom_req.data <= mcu_req.wdata;
        rom_rdy      <= 1'b0;
      end else if (rom_done) begin
        rom_req.rd <= 1'b0;
        rom_req.wr <= 1'b0;
        rom_rdy    <= 1'b1;
      end

      if (new_req && to_ram) begin
        ram_req.rd   <= mcu_req.rrq;
        ram_req.wr   <= mcu_req.wrq;
        // region tag stripped, only the offset reaches the SRAM
        ram_req.addr <= {5'b00000, mcu_req.addr.ram.offset};
        ram_req.data <= mcu_req.wdata;
        ram_rdy      <= 1'b0;
      end else if (ram_done) begin
        ram_req.rd <= 1'b0;
        ram_req.wr <= 1'b0;
        ram_rdy    <= 1'b1;
      end
    end
  end

  // read data from whichever side just finished a read
  always_ff @(posedge CLK2) begin
    if (rom_done && rom_req.rd)
      mcu_rdata <= rom_rd_byte;
    else if (ram_done && ram_req.rd)
      mcu_rdata <= ram_rd_byte;
  end

  assign mcu_rdy = rom_rdy & ram_rdy;

endmodule

// File: source/rom_access_seq.sv
module rom_access_seq (
  input  logic                             CLK2,
  input  logic                             reset,
  input  cart_pkg::snes_bus_t              bus,
  input  cart_pkg::snes_strobe_t           strobe,
  input  logic                             snes_dead,
  input  logic                             is_rom,
  input  logic                             is_saveram,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] rom_map_addr,
  input  cart_pkg::mem_req_t               req,
  input  logic [7:0]                       snes_ram_byte,
  inout  logic [15:0]                      rom_data,
  inout  logic [7:0]                       snes_data,
  output logic [cart_pkg::ROM_ADDR_W-1:0]  rom_addr,
  output logic                             rom_we,
  output logic                             rom_bhe,
  output logic                             rom_ble,
  output logic [7:0]                       snes_rom_byte,
  output logic                             snes_databus_oe,
  output logic                             snes_databus_dir,
  output logic                             done,
  output logic [7:0]                       rd_byte
);
  import cart_pkg::*;

  seq_state_e             state;
  logic [3:0]             delay;
  logic                   free_slot;
  logic                   mcu_active;
  logic                   wr_hit;
  logic                   addr0;
  logic                   snes_hit;
  logic [SNES_ADDR_W-1:0] addr_sel;

  assign free_slot = strobe.cycle_end | ~is_rom | snes_dead;

  // --------------------
  // slot FSM
  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (snes_dead && bus.cpu_clk) begin
      // console woke up, retry the access later
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot && req.rd) begin
            state <= ST_RD_ADDR;
            delay <= ROM_CYCLE_LEN;
          end else if (free_slot && req.wr) begin
            state <= ST_WR_ADDR;
            delay <= ROM_CYCLE_LEN;
          end
        end
        ST_RD_ADDR, ST_WR_ADDR: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0)
            state <= (state == ST_RD_ADDR) ? ST_RD_END : ST_WR_END;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // last sample before the end state wins
  always_ff @(posedge CLK2) begin
    if (state == ST_RD_ADDR)
      rd_byte <= snes_rom_byte;
  end

  assign mcu_active = state != ST_IDLE;
  assign wr_hit     = (state == ST_WR_ADDR) || (state == ST_WR_END);
  assign done       = (state == ST_RD_END) || (state == ST_WR_END);

  // --------------------
  // PSRAM side
  assign addr_sel = mcu_active ? req.addr : rom_map_addr;
  assign addr0    = addr_sel[0];
  assign rom_addr = addr_sel[ROM_ADDR_W:1];

  // odd bytes on the low lane, even bytes on the high lane
  assign rom_bhe = addr0;
  assign rom_ble = ~addr0;
  assign rom_we  = state != ST_WR_ADDR;

  assign rom_data[7:0]  = (wr_hit && addr0) ? req.data : 8'hzz;
  assign rom_data[15:8] = (wr_hit && !addr0) ? req.data : 8'hzz;

  assign snes_rom_byte = addr0 ? rom_data[7:0] : rom_data[15:8];

  // --------------------
  // SNES data bus
  assign snes_hit         = is_rom | is_saveram;
  assign snes_databus_oe  = ~(snes_hit & ~(bus.read & bus.write));
  // 1 drives toward the console
  assign snes_databus_dir = ~bus.read;

  assign snes_data = (snes_hit && !bus.read)
                   ? (is_saveram ? snes_ram_byte : snes_rom_byte)
                   : 8'hzz;

endmodule

// File: source/ram_access_seq.sv
module ram_access_seq (
  input  logic                            CLK2,
  input  logic                            reset,
  input  cart_pkg::snes_bus_t             bus,
  input  cart_pkg::snes_strobe_t          strobe,
  input  logic                            snes_dead,
  input  logic                            is_saveram,
  input  logic [cart_pkg::RAM_ADDR_W-1:0] ram_map_addr,
  input  cart_pkg::mem_req_t              req,
  input  logic [7:0]                      snes_data_in,
  inout  logic [7:0]                      ram_data,
  output logic [cart_pkg::RAM_ADDR_W-1:0] ram_addr,
  output logic                            ram_we,
  output logic [7:0]                      snes_ram_byte,
  output logic                            done,
  output logic [7:0]                      rd_byte
);
  import cart_pkg::*;

  seq_state_e state;
  logic [3:0] delay;
  logic       free_slot;
  logic       wr_hit;
  logic       snes_wr_hit;

  assign free_slot = strobe.cycle_end | ~is_saveram | snes_dead;

  // --------------------
  // slot FSM
  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (snes_dead && bus.cpu_clk) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot && req.rd) begin
            state <= ST_RD_ADDR;
            delay <= RAM_CYCLE_LEN;
          end else if (free_slot && req.wr) begin
            state <= ST_WR_ADDR;
            delay <= RAM_CYCLE_LEN;
          end
        end
        ST_RD_ADDR, ST_WR_ADDR: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0)
            state <= (state == ST_RD_ADDR) ? ST_RD_END : ST_WR_END;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == ST_RD_ADDR)
      rd_byte <= ram_data;
  end

  assign wr_hit = (state == ST_WR_ADDR) || (state == ST_WR_END);
  assign done   = (state == ST_RD_END) || (state == ST_WR_END);

  assign ram_addr = (state != ST_IDLE) ? req.addr[RAM_ADDR_W-1:0] : ram_map_addr;

  // SNES save RAM writes come before the MCU
  assign snes_wr_hit = is_saveram & ~bus.write;

  assign ram_data = snes_wr_hit ? snes_data_in
                  : wr_hit      ? req.data
                  : 8'hzz;

  assign ram_we = (is_saveram && bus.cpu_clk) ? bus.write : (state != ST_WR_ADDR);

  assign snes_ram_byte = ram_data;

endmodule

// File: source/cart_mem_ctrl.sv
module cart_mem_ctrl (
  input  logic                             CLK2,
  input  logic                             reset,
  input  logic [cart_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                             snes_read_in,
  input  logic                             snes_write_in,
  input  logic                             snes_romsel_in,
  input  logic                             snes_cpu_clk_in,
  inout  logic [7:0]                       snes_data,
  output logic                             snes_databus_oe,
  output logic                             snes_databus_dir,
  inout  logic [15:0]                      rom_data,
  output logic [cart_pkg::ROM_ADDR_W-1:0]  rom_addr,
  output logic                             rom_we,
  output logic                             rom_bhe,
  output logic                             rom_ble,
  inout  logic [7:0]                       ram_data,
  output logic [cart_pkg::RAM_ADDR_W-1:0]  ram_addr,
  output logic                             ram_we,
  input  cart_pkg::mcu_req_t               mcu_req,
  output logic                             mcu_rdy,
  output logic [7:0]                       mcu_rdata
);
  import cart_pkg::*;

  snes_bus_t              bus;
  snes_strobe_t           strobe;
  logic [7:0]             snes_data_in;
  logic                   snes_dead;
  logic                   is_rom;
  logic                   is_saveram;
  logic [SNES_ADDR_W-1:0] rom_map_addr;
  logic [RAM_ADDR_W-1:0]  ram_map_addr;
  mem_req_t               rom_req;
  mem_req_t               ram_req;
  logic                   rom_done;
  logic                   ram_done;
  logic [7:0]             rom_rd_byte;
  logic [7:0]             ram_rd_byte;
  logic [7:0]             snes_rom_byte;
  logic [7:0]             snes_ram_byte;

  // --------------------
  // SNES side
  snes_bus_sampler u_sampler (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data_raw   (snes_data),
    .bus             (bus),
    .strobe          (strobe),
    .snes_data_in    (snes_data_in)
  );

  snes_liveness u_liveness (
    .CLK2              (CLK2),
    .reset             (reset),
    .bus               (bus),
    .snes_dead         (snes_dead),
    .snes_reset_strobe ()
  );

  cart_addr_map u_addr_map (
    .bus          (bus),
    .is_rom       (is_rom),
    .is_saveram   (is_saveram),
    .rom_map_addr (rom_map_addr),
    .ram_map_addr (ram_map_addr)
  );

  // --------------------
  // MCU side and memories
  mcu_req_router u_router (
    .CLK2        (CLK2),
    .reset       (reset),
    .mcu_req     (mcu_req),
    .rom_done    (rom_done),
    .ram_done    (ram_done),
    .rom_rd_byte (rom_rd_byte),
    .ram_rd_byte (ram_rd_byte),
    .rom_req     (rom_req),
    .ram_req     (ram_req),
    .mcu_rdy     (mcu_rdy),
    .mcu_rdata   (mcu_rdata)
  );

  rom_access_seq u_rom_seq (
    .CLK2             (CLK2),
    .reset            (reset),
    .bus              (bus),
    .strobe           (strobe),
    .snes_dead        (snes_dead),
    .is_rom           (is_rom),
    .is_saveram       (is_saveram),
    .rom_map_addr     (rom_map_addr),
    .req              (rom_req),
    .snes_ram_byte    (snes_ram_byte),
    .rom_data         (rom_data),
    .snes_data        (snes_data),
    .rom_addr         (rom_addr),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .snes_rom_byte    (snes_rom_byte),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir),
    .done             (rom_done),
    .rd_byte          (rom_rd_byte)
  );

  ram_access_seq u_ram_seq (
    .CLK2          (CLK2),
    .reset         (reset),
    .bus           (bus),
    .strobe        (strobe),
    .snes_dead     (snes_dead),
    .is_saveram    (is_saveram),
    .ram_map_addr  (ram_map_addr),
    .req           (ram_req),
    .snes_data_in  (snes_data_in),
    .ram_data      (ram_data),
    .ram_addr      (ram_addr),
    .ram_we        (ram_we),
    .snes_ram_byte (snes_ram_byte),
    .done          (ram_done),
    .rd_byte       (ram_rd_byte)
  );

endmodule

// File: testbench/tb_cart_mems.sv
module tb_cart_mems (
  input  logic        CLK2,
  inout  logic [15:0] rom_data,
  input  logic [22:0] rom_addr,
  input  logic        rom_we,
  input  logic        rom_bhe,
  input  logic        rom_ble,
  inout  logic [7:0]  ram_data,
  input  logic [18:0] ram_addr,
  input  logic        ram_we
);
  timeunit 1ns;
  timeprecision 100ps;

  // only the low 16 address bits are decoded
  logic [15:0] psram [0:65535];
  logic [7:0]  sram  [0:65535];

  // write strobes sampled on the clock, lanes active low
  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe)
        psram[rom_addr[15:0]][15:8] <= rom_data[15:8];
      if (!rom_ble)
        psram[rom_addr[15:0]][7:0] <= rom_data[7:0];
    end
    if (!ram_we)
      sram[ram_addr[15:0]] <= ram_data;
  end

  assign rom_data = rom_we ? psram[rom_addr[15:0]] : 16'hzzzz;
  assign ram_data = ram_we ? sram[ram_addr[15:0]] : 8'hzz;

endmodule

// File: testbench/tb_cart_mem_ctrl.sv
module tb_cart_mem_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import cart_pkg::*;

  localparam int RDY_TIMEOUT      = 2000;
  localparam int SNES_LOW_CYCLES  = 6;
  localparam int SNES_HIGH_CYCLES = 8;

  logic                   CLK2;
  logic                   reset;
  logic [SNES_ADDR_W-1:0] snes_addr_in;
  logic                   snes_read_in;
  logic                   snes_write_in;
  logic                   snes_romsel_in;
  logic                   snes_cpu_clk_in;
  wire  [7:0]             snes_data;
  logic                   snes_databus_oe;
  logic                   snes_databus_dir;
  wire  [15:0]            rom_data;
  logic [ROM_ADDR_W-1:0]  rom_addr;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;
  wire  [7:0]             ram_data;
  logic [RAM_ADDR_W-1:0]  ram_addr;
  logic                   ram_we;
  mcu_req_t               mcu_req;
  logic                   mcu_rdy;
  logic [7:0]             mcu_rdata;

  // console side of the data bus
  logic                   snes_drive;
  logic [7:0]             snes_wdata;

  // kept from the ROM test for the RAM test
  logic [SNES_ADDR_W-1:0] rom_odd_addr;
  logic [SNES_ADDR_W-1:0] rom_even_addr;
  logic [7:0]             rom_odd_byte;
  logic [7:0]             rom_even_byte;

  assign snes_data = snes_drive ? snes_wdata : 8'hzz;

  cart_mem_ctrl i_dut (.*);

  tb_cart_mems u_mems (.*);

  always #10 CLK2 = ~CLK2;

  // --------------------
  // helpers

  // LoROM bank bits 6:0 then offset bits 14:0
  function automatic logic [23:0] lorom_rom_addr(input logic [23:0] addr);
    return {2'b00, addr[22:16], addr[14:0]} & ROM_MASK;
  endfunction

  function automatic logic [18:0] saveram_offset(input logic [23:0] addr);
    return {addr[19:16], addr[14:0]} & SAVERAM_MASK[18:0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual)
      abort_run($sformatf("** Error: %s expected %0h actual %0h", test, expected, actual));
  endtask

  // call on a falling edge
  task automatic wait_ready(input string test);
    int cycles;
    cycles = 0;
    while (mcu_rdy !== 1'b1) begin
      if (cycles == RDY_TIMEOUT) begin
        abort_run($sformatf("%s: mcu_rdy did not return within %0d cycles", test,
                            RDY_TIMEOUT));
      end else begin
        cycles++;
        @(negedge CLK2);
      end
    end
  endtask

  task automatic mcu_access(input string test, input logic rd, input logic [23:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    @(negedge CLK2);
    wait_ready(test);
    @(posedge CLK2);
    mcu_req.addr.flat <= addr;
    mcu_req.rrq       <= rd;
    mcu_req.wrq       <= !rd;
    mcu_req.wdata     <= wdata;
    @(posedge CLK2);
    mcu_req.rrq <= 1'b0;
    mcu_req.wrq <= 1'b0;
    @(negedge CLK2);
    check_eq({test, " busy"}, 0, mcu_rdy);
    wait_ready(test);
    rdata = mcu_rdata;
  endtask

  task automatic mcu_write(input string test, input logic [23:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    mcu_access(test, 1'b0, addr, data, unused);
  endtask

  task automatic mcu_read(input string test, input logic [23:0] addr, output logic [7:0] data);
    mcu_access(test, 1'b1, addr, 8'h00, data);
  endtask

  // one bus cycle with the address in the low phase and the strobe in the high phase
  task automatic snes_cycle(input logic [23:0] addr, input logic write_op,
                            input logic [7:0] wdata, output logic [7:0] rdata,
                            output logic dir, output logic oe);
    @(posedge CLK2);
    snes_addr_in    <= addr;
    snes_romsel_in  <= !(addr[22] || addr[15]);
    snes_cpu_clk_in <= 1'b0;
    repeat (SNES_LOW_CYCLES) @(posedge CLK2);
    snes_cpu_clk_in <= 1'b1;
    snes_read_in    <= write_op;
    snes_write_in   <= !write_op;
    snes_wdata      <= wdata;
    snes_drive      <= write_op;
    repeat (SNES_HIGH_CYCLES - 1) @(posedge CLK2);
    @(negedge CLK2);
    rdata = snes_data;
    dir   = snes_databus_dir;
    oe    = snes_databus_oe;
    @(posedge CLK2);
    snes_cpu_clk_in <= 1'b0;
    snes_read_in    <= 1'b1;
    snes_write_in   <= 1'b1;
    // data hold past the write strobe
    repeat (4) @(posedge CLK2);
    snes_drive <= 1'b0;
  endtask

  // --------------------
  // directed tests

  task automatic test_reset_values();
    @(negedge CLK2);
    check_eq("reset mcu_rdy", 1, mcu_rdy);
    check_eq("reset rom_we", 1, rom_we);
    check_eq("reset ram_we", 1, ram_we);
    check_eq("reset snes_databus_oe", 1, snes_databus_oe);
    check_eq("reset snes_databus_dir", 0, snes_databus_dir);
  endtask

  task automatic test_rom_dead();
    logic [7:0] got;
    rom_odd_addr  = {7'h00, 16'($urandom), 1'b1};
    // same PSRAM word, one byte per lane
    rom_even_addr = {rom_odd_addr[23:1], 1'b0};
    rom_odd_byte  = 8'($urandom);
    rom_even_byte = 8'($urandom);
    mcu_write("rom write odd", rom_odd_addr, rom_odd_byte);
    mcu_write("rom write even", rom_even_addr, rom_even_byte);
    mcu_read("rom read odd", rom_odd_addr, got);
    check_eq("rom read odd", rom_odd_byte, got);
    mcu_read("rom read even", rom_even_addr, got);
    check_eq("rom read even", rom_even_byte, got);
  endtask

  task automatic test_ram_dead();
    logic [23:0] ram_odd;
    logic [23:0] ram_even;
    logic [7:0]  ram_odd_byte;
    logic [7:0]  ram_even_byte;
    logic [7:0]  got;
    ram_odd       = {MCU_RAM_REGION, rom_odd_addr[18:0]};
    ram_even      = {MCU_RAM_REGION, rom_even_addr[18:0]};
    ram_odd_byte  = ~rom_odd_byte;
    ram_even_byte = ~rom_even_byte;
    mcu_write("ram write odd", ram_odd, ram_odd_byte);
    mcu_write("ram write even", ram_even, ram_even_byte);
    mcu_read("ram read odd", ram_odd, got);
    check_eq("ram read odd", ram_odd_byte, got);
    mcu_read("ram read even", ram_even, got);
    check_eq("ram read even", ram_even_byte, got);
    // ROM at the same offsets untouched
    mcu_read("rom recheck odd", rom_odd_addr, got);
    check_eq("rom recheck odd", rom_odd_byte, got);
    mcu_read("rom recheck even", rom_even_addr, got);
    check_eq("rom recheck even", rom_even_byte, got);
  endtask

  task automatic test_snes_rom_read();
    logic [23:0] addr;
    logic [7:0]  val;
    logic [7:0]  got;
    logic        dir;
    logic        oe;
    addr = {2'b00, 6'($urandom), 1'b1, 15'($urandom)};
    val  = 8'($urandom);
    mcu_write("snes rom preload", lorom_rom_addr(addr), val);
    snes_cycle(addr, 1'b0, 8'h00, got, dir, oe);
    check_eq("snes rom read data", val, got);
    check_eq("snes rom read dir", 1, dir);
    check_eq("snes rom read oe", 0, oe);
  endtask

  task automatic test_snes_saveram_write();
    logic [23:0] addr;
    logic [7:0]  val;
    logic [7:0]  got;
    logic        dir;
    logic        oe;
    addr = {8'h70, 1'b0, 15'($urandom)};
    val  = 8'($urandom);
    snes_cycle(addr, 1'b1, val, got, dir, oe);
    check_eq("snes saveram write dir", 0, dir);
    check_eq("snes saveram write oe", 0, oe);
    // CPU clock stopped long enough for the console to count as dead
    repeat (SNES_DEAD_TIMEOUT + 32) @(posedge CLK2);
    mcu_read("saveram read back", {MCU_RAM_REGION, saveram_offset(addr)}, got);
    check_eq("saveram read back", val, got);
  endtask

  task automatic test_mcu_under_traffic();
    logic [23:0] mcu_addr;
    logic [23:0] snes_addr;
    logic [7:0]  val;
    logic [7:0]  snes_val;
    logic [7:0]  got;
    logic [7:0]  snes_byte;
    logic        dir;
    logic        oe;
    mcu_addr  = {7'h00, 16'($urandom), 1'b1};
    // even SNES byte keeps the two preloads on different lanes
    snes_addr = {2'b00, 6'($urandom), 1'b1, 14'($urandom), 1'b0};
    val       = 8'($urandom);
    snes_val  = ~val;
    mcu_write("traffic preload", mcu_addr, val);
    mcu_write("traffic snes preload", lorom_rom_addr(snes_addr), snes_val);
    fork
      repeat (6) snes_cycle(snes_addr, 1'b0, 8'h00, snes_byte, dir, oe);
      mcu_read("traffic rom read", mcu_addr, got);
    join
    check_eq("traffic rom read", val, got);
    check_eq("traffic snes data", snes_val, snes_byte);
    check_eq("traffic snes dir", 1, dir);
    check_eq("traffic snes oe", 0, oe);
  endtask

  initial begin
    void'($urandom(32'h9c5c));
    CLK2            = 1'b0;
    reset           = 1'b1;
    snes_addr_in    = '0;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_cpu_clk_in = 1'b0;
    snes_drive      = 1'b0;
    snes_wdata      = 8'h00;
    mcu_req         = '0;
    repeat (4) @(posedge CLK2);
    reset <= 1'b0;

    test_reset_values();
    test_rom_dead();
    test_ram_dead();
    test_snes_rom_read();
    test_snes_saveram_write();
    test_mcu_under_traffic();

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: sources.f
source/cart_pkg.sv
source/snes_bus_sampler.sv
source/snes_liveness.sv
source/cart_addr_map.sv
source/mcu_req_router.sv
source/rom_access_seq.sv
source/ram_access_seq.sv
source/cart_mem_ctrl.sv
testbench/tb_cart_mems.sv
testbench/tb_cart_mem_ctrl.sv
